// File: mips_pkg.sv
////////////////////
// MIPS pipeline shared types
// Opcodes, function codes, ALU operations, forward
// selects and the stage-register structs
////////////////////
`default_nettype none

package mips_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  typedef enum logic [5:0] {
    op_rtype = 6'h00,
    op_j     = 6'h02,
    op_beq   = 6'h04,
    op_addi  = 6'h08,
    op_lw    = 6'h23,
    op_sw    = 6'h2b
  } opcode_e;

  typedef enum logic [5:0] {
    fn_add = 6'h20,
    fn_sub = 6'h22,
    fn_and = 6'h24,
    fn_or  = 6'h25,
    fn_slt = 6'h2a
  } funct_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_slt
  } alu_op_e;

  typedef enum logic [1:0] {
    fwd_rf,   // Operand from decode
    fwd_mem,  // From the execute/memory register
    fwd_wb    // From the memory/writeback register
  } fwd_sel_e;

  typedef struct packed {
    logic      valid;
    alu_op_e   alu_op;
    logic      use_imm;
    logic      reg_write;
    logic      is_load;
    logic      is_store;
    logic      is_branch;
    logic      is_jump;
    word_t     rs_val;
    word_t     rt_val;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t dest;
    word_t     imm;
    word_t     jump_target;
    word_t     pc4;
  } id_ex_t;

  typedef struct packed {
    logic      valid;
    logic      reg_write;
    logic      is_load;
    logic      is_store;
    reg_addr_t dest;
    word_t     alu_result;
    word_t     store_data;  // Already forwarded in execute
  } ex_mem_t;

endpackage

`default_nettype wire

// File: hazard_if.sv
////////////////////
// Hazard interface
// Register numbers, forward selects and stall
// between the stages and the hazard unit
////////////////////
`timescale 1ns/1ps
`default_nettype none

interface hazard_if import mips_pkg::*; ();
  reg_addr_t id_rs;
  reg_addr_t id_rt;
  reg_addr_t ex_rs;
  reg_addr_t ex_rt;
  logic      ex_is_load;
  reg_addr_t ex_dest;
  reg_addr_t mem_dest;
  logic      mem_we;
  reg_addr_t wb_dest;
  logic      wb_we;
  word_t     wb_data;
  logic      stall;
  fwd_sel_e  fwd_a;
  fwd_sel_e  fwd_b;

  modport decode  (output id_rs, id_rt, input stall);
  modport execute (output ex_rs, ex_rt, ex_is_load, ex_dest, input fwd_a, fwd_b, wb_data);
  modport mem     (output mem_dest, mem_we, wb_dest, wb_we, wb_data);
  modport hazard  (input id_rs, id_rt, ex_rs, ex_rt, ex_is_load, ex_dest,
                   input mem_dest, mem_we, wb_dest, wb_we,
                   output stall, fwd_a, fwd_b);
endinterface

`default_nettype wire

// File: fetch_stage.sv
////////////////////
// Fetch stage
// Program counter with redirect and hold,
// and the fetch/decode register
////////////////////
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import mips_pkg::*; #(
  parameter word_t RESET_PC = '0
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  stall,
  input  logic  freeze,
  input  logic  redirect,
  input  word_t redirect_pc,
  input  word_t instr,
  output word_t pc,
  output word_t if_id_instr,
  output word_t if_id_pc4,
  output logic  if_id_valid
);

  logic hold;

  assign hold = stall || freeze;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc          <= RESET_PC;
      if_id_valid <= 1'b0;
    end else if (redirect) begin
      pc          <= redirect_pc;
      if_id_valid <= 1'b0;  // Squash the wrong-path fetch
    end else if (!hold) begin
      pc          <= pc + 32'd4;
      if_id_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!hold && !redirect) begin
      if_id_instr <= instr;
      if_id_pc4   <= pc + 32'd4;
    end
  end

endmodule

`default_nettype wire

// File: decode_stage.sv
////////////////////
// Decode stage
// Instruction decoder, 32-entry register file with
// write bypass, and the decode/execute register
////////////////////
`timescale 1ns/1ps
`default_nettype none

module decode_stage import mips_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  word_t     if_id_instr,
  input  word_t     if_id_pc4,
  input  logic      if_id_valid,
  input  logic      freeze,
  input  logic      redirect,
  input  logic      rf_we,
  input  reg_addr_t rf_addr,
  input  word_t     rf_data,
  hazard_if.decode  hz,
  output id_ex_t    id_ex
);

  word_t     regs [32];
  opcode_e   opcode;
  funct_e    funct;
  reg_addr_t rs;
  reg_addr_t rt;
  reg_addr_t rd;
  word_t     rs_val;
  word_t     rt_val;
  id_ex_t    nxt;

  assign opcode = opcode_e'(if_id_instr[31:26]);
  assign funct  = funct_e'(if_id_instr[5:0]);
  assign rs     = if_id_instr[25:21];
  assign rt     = if_id_instr[20:16];
  assign rd     = if_id_instr[15:11];

  // Register 0 reads as zero, same-cycle write is bypassed
  assign rs_val = (rs == '0) ? '0 : (rf_we && rf_addr == rs) ? rf_data : regs[rs];
  assign rt_val = (rt == '0) ? '0 : (rf_we && rf_addr == rt) ? rf_data : regs[rt];

  assign hz.id_rs = if_id_valid ? rs : '0;
  assign hz.id_rt = if_id_valid ? rt : '0;

  always_ff @(posedge clk) begin
    if (rf_we && rf_addr != '0) begin
      regs[rf_addr] <= rf_data;
    end
  end

  always_comb begin
    nxt             = '0;
    nxt.valid       = if_id_valid;
    nxt.alu_op      = alu_add;
    nxt.rs_val      = rs_val;
    nxt.rt_val      = rt_val;
    nxt.rs          = rs;
    nxt.rt          = rt;
    nxt.dest        = rt;  // I-type default
    nxt.imm         = {{16{if_id_instr[15]}}, if_id_instr[15:0]};
    nxt.jump_target = {if_id_pc4[31:28], if_id_instr[25:0], 2'b00};
    nxt.pc4         = if_id_pc4;
    case (opcode)
      op_rtype: begin
        nxt.dest      = rd;
        nxt.reg_write = 1'b1;
        case (funct)
          fn_add:  nxt.alu_op = alu_add;
          fn_sub:  nxt.alu_op = alu_sub;
          fn_and:  nxt.alu_op = alu_and;
          fn_or:   nxt.alu_op = alu_or;
          fn_slt:  nxt.alu_op = alu_slt;
          default: nxt.reg_write = 1'b0;  // Unknown funct acts as nop
        endcase
      end
      op_addi: begin
        nxt.use_imm   = 1'b1;
        nxt.reg_write = 1'b1;
      end
      op_lw: begin
        nxt.use_imm   = 1'b1;
        nxt.reg_write = 1'b1;
        nxt.is_load   = 1'b1;
      end
      op_sw: begin
        nxt.use_imm  = 1'b1;
        nxt.is_store = 1'b1;
      end
      op_beq:  nxt.is_branch = 1'b1;
      op_j:    nxt.is_jump = 1'b1;
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_ex <= '0;
    end else if (!freeze) begin
      id_ex <= (hz.stall || redirect) ? '0 : nxt;  // Bubble on load-use or flush
    end
  end

endmodule

`default_nettype wire

// File: hazard_unit.sv
////////////////////
// Hazard unit
// Load-use stall detection and forward
// selection for both execute operands
////////////////////
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import mips_pkg::*; (
  hazard_if.hazard hz
);

  function automatic fwd_sel_e pick_src(
    input reg_addr_t src,
    input logic      mem_we,
    input reg_addr_t mem_dest,
    input logic      wb_we,
    input reg_addr_t wb_dest
  );
    fwd_sel_e sel;
    sel = fwd_rf;
    // Youngest producer wins
    if (src != '0 && mem_we && mem_dest == src) begin
      sel = fwd_mem;
    end else if (src != '0 && wb_we && wb_dest == src) begin
      sel = fwd_wb;
    end
    return sel;
  endfunction

  assign hz.stall = hz.ex_is_load && hz.ex_dest != '0 &&
                    (hz.ex_dest == hz.id_rs || hz.ex_dest == hz.id_rt);

  assign hz.fwd_a = pick_src(hz.ex_rs, hz.mem_we, hz.mem_dest, hz.wb_we, hz.wb_dest);
  assign hz.fwd_b = pick_src(hz.ex_rt, hz.mem_we, hz.mem_dest, hz.wb_we, hz.wb_dest);

endmodule

`default_nettype wire

// File: execute_stage.sv
////////////////////
// Execute stage
// Operand forwarding, ALU, branch and jump
// resolution, and the execute/memory register
////////////////////
`timescale 1ns/1ps
`default_nettype none

module execute_stage import mips_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  id_ex_t    id_ex,
  input  logic      freeze,
  input  word_t     mem_result,
  hazard_if.execute hz,
  output logic      redirect,
  output word_t     redirect_pc,
  output ex_mem_t   ex_mem
);

  word_t op_a;
  word_t op_b;
  word_t alu_b;
  word_t alu_y;
  word_t br_target;
  logic  taken;

  assign hz.ex_rs      = id_ex.rs;
  assign hz.ex_rt      = id_ex.rt;
  assign hz.ex_is_load = id_ex.valid && id_ex.is_load;
  assign hz.ex_dest    = id_ex.dest;

  always_comb begin
    case (hz.fwd_a)
      fwd_mem: op_a = mem_result;
      fwd_wb:  op_a = hz.wb_data;
      default: op_a = id_ex.rs_val;
    endcase
    case (hz.fwd_b)
      fwd_mem: op_b = mem_result;
      fwd_wb:  op_b = hz.wb_data;
      default: op_b = id_ex.rt_val;
    endcase
  end

  assign alu_b = id_ex.use_imm ? id_ex.imm : op_b;

  always_comb begin
    case (id_ex.alu_op)
      alu_sub: alu_y = op_a - alu_b;
      alu_and: alu_y = op_a & alu_b;
      alu_or:  alu_y = op_a | alu_b;
      alu_slt: alu_y = {31'd0, $signed(op_a) < $signed(alu_b)};
      default: alu_y = op_a + alu_b;
    endcase
  end

  // beq compares the forwarded register operands, not the immediate path
  assign taken = id_ex.valid && (id_ex.is_jump || (id_ex.is_branch && op_a == op_b));
  assign br_target   = id_ex.pc4 + {id_ex.imm[29:0], 2'b00};
  assign redirect    = taken && !freeze;  // Only once the stage advances
  assign redirect_pc = id_ex.is_jump ? id_ex.jump_target : br_target;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_mem <= '0;
    end else if (!freeze) begin
      ex_mem.valid      <= id_ex.valid;
      ex_mem.reg_write  <= id_ex.reg_write;
      ex_mem.is_load    <= id_ex.is_load;
      ex_mem.is_store   <= id_ex.is_store;
      ex_mem.dest       <= id_ex.dest;
      ex_mem.alu_result <= alu_y;
      ex_mem.store_data <= op_b;
    end
  end

endmodule

`default_nettype wire

// File: mem_wb_stage.sv
////////////////////
// Memory and writeback stage
// Wishbone classic data master, memory/writeback
// register and register-file write port
////////////////////
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage import mips_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  ex_mem_t   ex_mem,
  input  logic      ack,
  input  word_t     dat_r,
  output logic      cyc,
  output logic      stb,
  output logic      we,
  output word_t     adr,
  output word_t     dat_w,
  output logic      freeze,
  output logic      rf_we,
  output reg_addr_t rf_addr,
  output word_t     rf_data,
  output word_t     mem_result,
  hazard_if.mem     hz
);

  typedef enum logic {st_idle, st_bus} bus_state_e;

  bus_state_e state;
  logic       mem_op;
  logic       bus_active;
  logic       wb_we;
  logic       wb_fresh;  // Set only in the first cycle after a load of the register
  reg_addr_t  wb_dest;
  word_t      wb_data;

  assign mem_op     = ex_mem.valid && (ex_mem.is_load || ex_mem.is_store);
  assign bus_active = (state == st_bus);

  assign cyc   = bus_active;
  assign stb   = bus_active;
  assign we    = bus_active && ex_mem.is_store;
  assign adr   = ex_mem.alu_result;
  assign dat_w = ex_mem.store_data;

  // Hold everything until the slave acks
  assign freeze     = mem_op && !(bus_active && ack);
  assign mem_result = ex_mem.alu_result;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: if (mem_op) state <= st_bus;
        st_bus:  if (ack) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_we    <= 1'b0;
      wb_fresh <= 1'b0;
    end else begin
      wb_fresh <= !freeze && ex_mem.valid && ex_mem.reg_write && ex_mem.dest != '0;
      if (!freeze) begin
        wb_we <= ex_mem.valid && ex_mem.reg_write && ex_mem.dest != '0;  // r0 dropped
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!freeze) begin
      wb_dest <= ex_mem.dest;
      wb_data <= ex_mem.is_load ? dat_r : ex_mem.alu_result;
    end
  end

  assign rf_we   = wb_fresh;
  assign rf_addr = wb_dest;
  assign rf_data = wb_data;

  assign hz.mem_dest = ex_mem.dest;
  assign hz.mem_we   = ex_mem.valid && ex_mem.reg_write;
  assign hz.wb_dest  = wb_dest;
  assign hz.wb_we    = wb_we;
  assign hz.wb_data  = wb_data;

endmodule

`default_nettype wire

// File: mips_pipeline.sv
////////////////////
// MIPS five-stage pipeline, top level
// Instruction read port, Wishbone data port
// and register-write retire port
////////////////////
`timescale 1ns/1ps
`default_nettype none

module mips_pipeline import mips_pkg::*; #(
  parameter word_t RESET_PC = '0
) (
  input  logic      clk,
  input  logic      rst_n,
  input  word_t     imem_data,
  input  logic      ack,
  input  word_t     dat_r,
  output word_t     imem_addr,
  output logic      cyc,
  output logic      stb,
  output logic      we,
  output word_t     adr,
  output word_t     dat_w,
  output logic      retire_valid,
  output reg_addr_t retire_reg,
  output word_t     retire_data
);

  word_t   if_id_instr;
  word_t   if_id_pc4;
  logic    if_id_valid;
  id_ex_t  id_ex;
  ex_mem_t ex_mem;
  logic    redirect;
  word_t   redirect_pc;
  logic    freeze;
  word_t   mem_result;

  hazard_if hz ();

  fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
    .clk(clk), .rst_n(rst_n), .stall(hz.stall), .freeze(freeze),
    .redirect(redirect), .redirect_pc(redirect_pc), .instr(imem_data),
    .pc(imem_addr), .if_id_instr(if_id_instr), .if_id_pc4(if_id_pc4),
    .if_id_valid(if_id_valid)
  );

  decode_stage u_decode (
    .clk(clk), .rst_n(rst_n), .if_id_instr(if_id_instr), .if_id_pc4(if_id_pc4),
    .if_id_valid(if_id_valid), .freeze(freeze), .redirect(redirect),
    .rf_we(retire_valid), .rf_addr(retire_reg), .rf_data(retire_data),
    .hz(hz.decode), .id_ex(id_ex)
  );

  hazard_unit u_hazard (.hz(hz.hazard));

  execute_stage u_execute (
    .clk(clk), .rst_n(rst_n), .id_ex(id_ex), .freeze(freeze), .mem_result(mem_result),
    .hz(hz.execute), .redirect(redirect), .redirect_pc(redirect_pc), .ex_mem(ex_mem)
  );

  mem_wb_stage u_mem_wb (
    .clk(clk), .rst_n(rst_n), .ex_mem(ex_mem), .ack(ack), .dat_r(dat_r),
    .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w), .freeze(freeze),
    .rf_we(retire_valid), .rf_addr(retire_reg), .rf_data(retire_data),
    .mem_result(mem_result), .hz(hz.mem)
  );

endmodule

`default_nettype wire

// File: mips_pipeline_checker.sv
////////////////////
// MIPS pipeline checker
// Assertions on the Wishbone data port
// and the retire port, bound to the top level
////////////////////
`timescale 1ns/1ps
`default_nettype none

module mips_pipeline_checker import mips_pkg::*; (
  input logic      clk,
  input logic      rst_n,
  input logic      cyc,
  input logic      stb,
  input logic      we,
  input word_t     adr,
  input word_t     dat_w,
  input logic      ack,
  input logic      retire_valid,
  input reg_addr_t retire_reg
);

  a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n) stb |-> cyc)
    else $error("stb high without cyc");

  // Request held steady until the slave answers
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (stb && !ack) |=> ($stable(adr) && $stable(we) && $stable(dat_w)))
    else $error("Wishbone request changed before ack");

  a_no_r0_retire: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid |-> (retire_reg != '0))
    else $error("retire shown for register 0");

  a_idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !cyc)
    else $error("cyc high in the first cycle after reset");

endmodule

bind mips_pipeline mips_pipeline_checker u_checker (
  .clk(clk), .rst_n(rst_n), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
  .dat_w(dat_w), .ack(ack), .retire_valid(retire_valid), .retire_reg(retire_reg)
);

`default_nettype wire

// File: tb_mips_pipeline.sv
////////////////////
// MIPS pipeline testbench
// Random programs run against an instruction-set
// model, with a Wishbone memory and retire checks
////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_mips_pipeline import mips_pkg::*; ();

  localparam int    NUM_PROGS      = 8;
  localparam int    PROG_LEN       = 40;
  localparam int    MEM_WORDS      = 64;
  localparam int    CLK_PERIOD     = 20;
  localparam int    DRAIN_CYCLES   = 16;
  localparam int    TIMEOUT_CYCLES = NUM_PROGS * PROG_LEN * 12;
  localparam word_t RESET_PC       = 32'h0;

  logic      clk;
  logic      rst_n;
  word_t     imem_data;
  logic      ack;
  word_t     dat_r;
  word_t     imem_addr;
  logic      cyc;
  logic      stb;
  logic      we;
  word_t     adr;
  word_t     dat_w;
  logic      retire_valid;
  reg_addr_t retire_reg;
  word_t     retire_data;

  word_t       prog [MEM_WORDS];
  word_t       bus_mem [MEM_WORDS];    // Seen by the Wishbone slave
  word_t       model_mem [MEM_WORDS];  // Seen by the ISA model
  word_t       model_regs [32];
  reg_addr_t   exp_reg_q [$];
  word_t       exp_data_q [$];
  word_t       exp_adr_q [$];
  word_t       exp_st_q [$];
  int          err_count;
  int          check_count;
  int unsigned seed_val;

  // Past the end of the program every fetch is a nop
  assign imem_data = (imem_addr[31:2] < PROG_LEN) ? prog[imem_addr[7:2]] : 32'h0;

  mips_pipeline #(.RESET_PC(RESET_PC)) u_dut (
    .clk(clk), .rst_n(rst_n), .imem_data(imem_data), .ack(ack), .dat_r(dat_r),
    .imem_addr(imem_addr), .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w),
    .retire_valid(retire_valid), .retire_reg(retire_reg), .retire_data(retire_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic word_t enc_rtype(funct_e fn, reg_addr_t rd, reg_addr_t rs, reg_addr_t rt);
    return {op_rtype, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic word_t enc_itype(opcode_e op, reg_addr_t rs, reg_addr_t rt,
                                      logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t enc_jump(logic [25:0] idx);
    return {op_j, idx};
  endfunction

  function automatic word_t fill_word(int p, int idx);
    return (word_t'(idx) * 32'h9e3779b9) ^ {8'(p), 24'h3c5a96};
  endfunction

  task automatic gen_program();
    int          i;
    int          kind;
    reg_addr_t   ra;
    reg_addr_t   rb;
    reg_addr_t   rc;
    logic [15:0] imm;
    for (i = 0; i < MEM_WORDS; i++) begin
      prog[i] = 32'h0;
    end
    for (i = 1; i < 8; i++) begin  // Prologue gives r1..r7 known values
      prog[i - 1] = enc_itype(op_addi, 5'd0, 5'(i), 16'($urandom));
    end
    for (i = 7; i < PROG_LEN; i++) begin
      ra   = 5'($urandom_range(0, 7));
      rb   = 5'($urandom_range(0, 7));
      rc   = 5'($urandom_range(0, 7));
      imm  = 16'(($urandom_range(0, 1) ? $urandom_range(0, 7)
                                       : $urandom_range(0, MEM_WORDS - 1)) * 4);
      kind = $urandom_range(0, 11);
      case (kind)
        0: prog[i] = enc_rtype(fn_add, rc, ra, rb);
        1: prog[i] = enc_rtype(fn_sub, rc, ra, rb);
        2: prog[i] = enc_rtype(fn_and, rc, ra, rb);
        3: prog[i] = enc_rtype(fn_or, rc, ra, rb);
        4: prog[i] = enc_rtype(fn_slt, rc, ra, rb);
        5, 6: prog[i] = enc_itype(op_addi, ra, rb, 16'($urandom));
        7, 8: prog[i] = enc_itype(op_lw, 5'd0, rb, imm);
        9: prog[i] = enc_itype(op_sw, 5'd0, rb, imm);
        10: begin
          if ($urandom_range(0, 1)) rb = ra;  // Equal registers force a taken beq
          prog[i] = enc_itype(op_beq, ra, rb, 16'($urandom_range(0, 3)));
        end
        default: prog[i] = enc_jump(26'(i + 1 + $urandom_range(0, 3)));
      endcase
    end
  endtask

  // Sequential instruction-set model
  task automatic run_model();
    int        pc_idx;
    int        next_idx;
    word_t     ins;
    word_t     a;
    word_t     b;
    word_t     simm;
    word_t     addr;
    word_t     res;
    reg_addr_t dest;
    logic      wr;
    for (pc_idx = 0; pc_idx < 32; pc_idx++) begin
      model_regs[pc_idx] = '0;
    end
    pc_idx = 0;
    while (pc_idx < PROG_LEN) begin
      ins      = prog[pc_idx];
      a        = model_regs[ins[25:21]];
      b        = model_regs[ins[20:16]];
      simm     = {{16{ins[15]}}, ins[15:0]};
      next_idx = pc_idx + 1;
      dest     = ins[20:16];
      wr       = 1'b0;
      res      = '0;
      case (ins[31:26])
        op_rtype: begin
          wr   = 1'b1;
          dest = ins[15:11];
          case (ins[5:0])
            fn_add:  res = a + b;
            fn_sub:  res = a - b;
            fn_and:  res = a & b;
            fn_or:   res = a | b;
            fn_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: wr = 1'b0;
          endcase
        end
        op_addi: begin
          wr  = 1'b1;
          res = a + simm;
        end
        op_lw: begin
          addr = a + simm;
          res  = model_mem[addr[7:2]];
          wr   = 1'b1;
        end
        op_sw: begin
          addr = a + simm;
          exp_adr_q.push_back(addr);
          exp_st_q.push_back(b);
          model_mem[addr[7:2]] = b;
        end
        op_beq: if (a == b) next_idx = pc_idx + 1 + int'($signed(simm));
        op_j:   next_idx = int'(ins[25:0]);
        default: ;
      endcase
      if (wr && dest != '0) begin
        model_regs[dest] = res;
        exp_reg_q.push_back(dest);
        exp_data_q.push_back(res);
      end
      pc_idx = next_idx;
    end
  endtask

  task automatic check_store();
    word_t exp_a;
    word_t exp_d;
    check_count++;
    if (exp_adr_q.size() == 0) begin
      $display("Unexpected Wishbone write to address %h", adr);
      err_count++;
    end else begin
      exp_a = exp_adr_q.pop_front();
      exp_d = exp_st_q.pop_front();
      if (adr !== exp_a) begin
        $display("ERR adr expected %h got %h", exp_a, adr);
        err_count++;
      end
      if (dat_w !== exp_d) begin
        $display("ERR dat_w expected %h got %h", exp_d, dat_w);
        err_count++;
      end
    end
  endtask

  task automatic check_retire();
    reg_addr_t exp_r;
    word_t     exp_d;
    check_count++;
    if (exp_reg_q.size() == 0) begin
      $display("Unexpected register write to r%0d with data %h", retire_reg, retire_data);
      err_count++;
    end else begin
      exp_r = exp_reg_q.pop_front();
      exp_d = exp_data_q.pop_front();
      if (retire_reg !== exp_r) begin
        $display("ERR retire_reg expected %h got %h", exp_r, retire_reg);
        err_count++;
      end
      if (retire_data !== exp_d) begin
        $display("ERR retire_data expected %h got %h", exp_d, retire_data);
        err_count++;
      end
    end
  endtask

  // Slave answers one bus cycle after 0 to 3 wait cycles
  task automatic serve_bus();
    int         waits;
    logic [5:0] idx;
    @(negedge clk);
    if (rst_n && cyc && stb) begin
      waits = $urandom_range(0, 3);
      repeat (waits) @(negedge clk);
      idx = adr[7:2];
      if (we) begin
        check_store();
        bus_mem[idx] = dat_w;
      end else begin
        dat_r = bus_mem[idx];
      end
      ack = 1'b1;
      @(negedge clk);
      ack   = 1'b0;
      dat_r = '0;
    end
  endtask

  initial begin
    forever serve_bus();
  end

  always @(negedge clk) begin
    if (rst_n && retire_valid) check_retire();
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles, the pipeline stopped making progress", TIMEOUT_CYCLES);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    int p;
    int idx;
    int errs_before;
    int n_ret;
    int n_st;
    seed_val    = $urandom(32'hc3a64c55);
    rst_n       = 1'b0;
    ack         = 1'b0;
    dat_r       = '0;
    err_count   = 0;
    check_count = 0;
    for (p = 0; p < NUM_PROGS; p++) begin
      @(negedge clk);
      rst_n       = 1'b0;
      errs_before = err_count;
      gen_program();
      for (idx = 0; idx < MEM_WORDS; idx++) begin
        bus_mem[idx]   = fill_word(p, idx);
        model_mem[idx] = fill_word(p, idx);
      end
      exp_reg_q.delete();
      exp_data_q.delete();
      exp_adr_q.delete();
      exp_st_q.delete();
      run_model();
      n_ret = exp_reg_q.size();
      n_st  = exp_adr_q.size();
      repeat (4) @(negedge clk);
      rst_n = 1'b1;
      check_count++;
      if (imem_addr !== RESET_PC) begin
        $display("ERR imem_addr expected %h got %h", RESET_PC, imem_addr);
        err_count++;
      end
      @(negedge clk);
      check_count++;
      if (retire_valid !== 1'b0) begin
        $display("ERR retire_valid expected %h got %h", 1'b0, retire_valid);
        err_count++;
      end
      check_count++;
      if (cyc !== 1'b0) begin
        $display("ERR cyc expected %h got %h", 1'b0, cyc);
        err_count++;
      end
      while (exp_reg_q.size() != 0 || exp_adr_q.size() != 0) @(negedge clk);
      while (cyc) @(negedge clk);
      repeat (DRAIN_CYCLES) @(negedge clk);  // Catch late wrong-path writes
      $display("program %0d: %0d register writes, %0d stores, %0s", p, n_ret, n_st,
               (err_count == errs_before) ? "matched" : "mismatched");
    end
    $display("programs %0d, checks %0d, errors %0d", NUM_PROGS, check_count, err_count);
    if (err_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
mips_pkg.sv
hazard_if.sv
fetch_stage.sv
decode_stage.sv
hazard_unit.sv
execute_stage.sv
mem_wb_stage.sv
mips_pipeline.sv
mips_pipeline_checker.sv
tb_mips_pipeline.sv
